// File: Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert
TOP      = tb_mcr_input
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: files.f
+incdir+hdl
hdl/mcr_input_pkg.sv
hdl/config_regs.sv
hdl/control_merge.sv
hdl/spinner_accum.sv
hdl/input_port_map.sv
hdl/mcr_input_top.sv
testbench/tb_mcr_input.sv

// File: hdl/config_regs.sv
`timescale 1ns/1ps

`include "mcr_input_macros.svh"

module config_regs import mcr_input_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  wb_m2s_t                wb_req,
	output wb_s2m_t                wb_rsp,
	output game_e                  game,
	output logic                   game_ok,
	output logic [`MCR_PORT_W-1:0] dip0,
	output logic                   service
);

	localparam int DIP_AW = $clog2(`MCR_DIP_COUNT);
	localparam logic [`MCR_WB_ADR_W-1:0] MODE_ADR = `MCR_WB_ADR_W'(`MCR_MODE_ADR);

	logic [7:0]        dip [`MCR_DIP_COUNT];
	logic [7:0]        mode;
	logic              ack;
	logic              req;
	logic              wr;
	logic              dip_hit;
	logic              mode_hit;
	logic [DIP_AW-1:0] dip_idx;
	logic [7:0]        rd_dat;
	logic [7:0]        rd_q;

	// ============================================================
	// Wishbone classic slave, one ack per request
	// ============================================================

	// A request is new as long as it has not been acked yet
	assign req      = wb_req.cyc & wb_req.stb & ~ack;
	assign wr       = req & wb_req.we;
	assign dip_hit  = (wb_req.adr >> DIP_AW) == '0;
	assign mode_hit = wb_req.adr == MODE_ADR;
	assign dip_idx  = wb_req.adr[DIP_AW-1:0];

	always_comb begin
		if (dip_hit)
			rd_dat = dip[dip_idx];
		else if (mode_hit)
			rd_dat = mode;
		else
			rd_dat = `MCR_PORT_IDLE;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ack  <= 1'b0;
			mode <= '0;
			for (int i = 0; i < `MCR_DIP_COUNT; i++)
				dip[i] <= `MCR_PORT_IDLE;
		end else begin
			ack <= req;
			if (wr && dip_hit)
				dip[dip_idx] <= wb_req.dat;
			if (wr && mode_hit)
				mode <= wb_req.dat;
		end
	end

	// Read data goes out together with ack
	always_ff @(posedge clk_sys) begin
		rd_q <= rd_dat;
	end

	assign wb_rsp = '{ack: ack, dat: rd_q};

	// ============================================================
	// Game decode and DIP outputs
	// ============================================================

	// Mode values above 3 select no game at all
	assign game    = game_e'(mode[1:0]);
	assign game_ok = mode[7:2] == '0;
	assign dip0    = dip[0];
	assign service = dip[1][0];

	a_ack_single: assert property (@(posedge clk_sys) disable iff (rst)
		ack |=> !ack);

	a_ack_after_req: assert property (@(posedge clk_sys) disable iff (rst)
		ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

// File: hdl/control_merge.sv
`timescale 1ns/1ps

`include "mcr_input_macros.svh"

module control_merge import mcr_input_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  joy_t                   joy1,
	input  joy_t                   joy2,
	input  logic [`MCR_SPIN_W-1:0] spin1,
	input  logic [`MCR_SPIN_W-1:0] spin2,
	output ctrl_t                  ctrl
);

	logic [`MCR_SPIN_W-1:0] spin1_q;
	logic [`MCR_SPIN_W-1:0] spin2_q;
	logic                   sel;
	logic                   sel_next;
	pad_t                   pad1;
	pad_t                   pad2;

	// Pull the named buttons out of a joystick word
	// Digital spin buttons act as the rotate buttons
	function automatic pad_t fold(input joy_t j);
		pad_t p;
		p.coin   = j.coin;
		p.start2 = j.start2;
		p.start1 = j.start1;
		p.rccw   = j.rccw | j.spin_ccw;
		p.rcw    = j.rcw | j.spin_cw;
		p.fire_d = j.fire_d;
		p.fire_c = j.fire_c;
		p.fire_b = j.fire_b;
		p.fire_a = j.fire_a;
		p.up     = j.up;
		p.down   = j.down;
		p.left   = j.left;
		p.right  = j.right;
		return p;
	endfunction

	assign pad1 = fold(joy1);
	assign pad2 = fold(joy2);

	// ============================================================
	// Spinner source, the one that moved last
	// ============================================================

	always_comb begin
		sel_next = sel;
		if (spin1 != spin1_q)
			sel_next = 1'b0;
		// Player two wins when both move in the same cycle
		if (spin2 != spin2_q)
			sel_next = 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			sel <= 1'b0;
		else
			sel <= sel_next;
	end

	// Input history and the stage record
	always_ff @(posedge clk_sys) begin
		spin1_q     <= spin1;
		spin2_q     <= spin2;
		ctrl.merged <= pad1 | pad2;
		ctrl.p1     <= pad1;
		ctrl.p2     <= pad2;
		ctrl.spin   <= sel_next ? spin2 : spin1;
		ctrl.pos    <= '0;
	end

endmodule

// File: hdl/input_port_map.sv
`timescale 1ns/1ps

`include "mcr_input_macros.svh"

module input_port_map import mcr_input_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  ctrl_t                  ctrl,
	input  game_e                  game,
	input  logic                   game_ok,
	input  logic [`MCR_PORT_W-1:0] dip0,
	input  logic                   service,
	output logic [`MCR_PORT_W-1:0] port0,
	output logic [`MCR_PORT_W-1:0] port1,
	output logic [`MCR_PORT_W-1:0] port2,
	output logic [`MCR_PORT_W-1:0] port3,
	output logic                   landscape
);

	pad_t                   m;
	pad_t                   a;
	pad_t                   b;
	logic                   coin;
	logic [`MCR_PORT_W-1:0] nxt0;
	logic [`MCR_PORT_W-1:0] nxt1;
	logic [`MCR_PORT_W-1:0] nxt2;
	logic                   land_nxt;

	assign m = ctrl.merged;
	assign a = ctrl.p1;
	assign b = ctrl.p2;

	// Discs of Tron has no coin button, either start inserts a coin
	assign coin = m.coin | ((game == GAME_DOTRON) & (m.start1 | m.start2));

	// ============================================================
	// Port layout per game, bits built active high then inverted
	// ============================================================

	always_comb begin
		nxt0     = `MCR_PORT_IDLE;
		nxt1     = `MCR_PORT_IDLE;
		nxt2     = `MCR_PORT_IDLE;
		land_nxt = 1'b1;
		if (game_ok) begin
			case (game)
				GAME_TAPPER: begin
					nxt0 = ~{service, 3'b000, m.start2, m.start1, 1'b0, coin};
					nxt1 = ~{3'b000, m.fire_a, m.up, m.down, m.left, m.right};
					nxt2 = nxt1;
				end
				GAME_TIMBER: begin
					nxt0 = ~{service, 3'b000, m.start2, m.start1, 1'b0, coin};
					nxt1 = ~{2'b00, a.fire_a, a.fire_b, a.up, a.down, a.left, a.right};
					nxt2 = ~{2'b00, b.fire_a, b.fire_b, b.up, b.down, b.left, b.right};
				end
				GAME_DOTRON: begin
					nxt0 = ~{service, 2'b00, m.fire_a, m.start2, m.start1, 1'b0, coin};
					// Top seven position bits, the LSB is dropped
					nxt1 = ~{1'b0, ctrl.pos[`MCR_POS_W-1:1]};
					nxt2 = ~{1'b0, m.fire_b, m.fire_c, m.fire_d, m.down, m.up, m.right, m.left};
				end
				GAME_JOURNEY: begin
					nxt0     = ~{service, 2'b00, m.fire_a, m.start2, m.start1, 1'b0, coin};
					nxt1     = ~{4'b0000, m.down, m.up, m.right, m.left};
					nxt2     = ~{3'b000, m.fire_a, m.down, m.up, m.right, m.left};
					land_nxt = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			port0     <= `MCR_PORT_IDLE;
			port1     <= `MCR_PORT_IDLE;
			port2     <= `MCR_PORT_IDLE;
			port3     <= `MCR_PORT_IDLE;
			landscape <= 1'b1;
		end else begin
			port0     <= nxt0;
			port1     <= nxt1;
			port2     <= nxt2;
			port3     <= dip0;
			landscape <= land_nxt;
		end
	end

endmodule

// File: hdl/mcr_input_macros.svh
`ifndef MCR_INPUT_MACROS_SVH
`define MCR_INPUT_MACROS_SVH

// ============================================================
// Player input path constants
// ============================================================

// Spinner position change per vsync strobe from the rotate buttons
`define MCR_SPIN_STEP 8'd5

// Spinner word from the analog input, bit 8 toggles on each new delta
`define MCR_SPIN_W 9

// Accumulated spin position
`define MCR_POS_W 8

// Width of one CPU input port
`define MCR_PORT_W 8

// Idle value of a port, all inputs released (active low)
`define MCR_PORT_IDLE 8'hff

// ============================================================
// Configuration bus
// ============================================================

`define MCR_DIP_COUNT 8
`define MCR_MODE_ADR 8
`define MCR_WB_ADR_W 4

`endif

// File: hdl/mcr_input_pkg.sv
package mcr_input_pkg;

`include "mcr_input_macros.svh"

	// One joystick word as delivered by the host
	typedef struct packed {
		logic        spin_cw;
		logic        spin_ccw;
		logic [16:0] unused;
		logic        coin;
		logic        start2;
		logic        start1;
		logic        rccw;
		logic        rcw;
		logic        fire_d;
		logic        fire_c;
		logic        fire_b;
		logic        fire_a;
		logic        up;
		logic        down;
		logic        left;
		logic        right;
	} joy_t;

	// Named buttons of one player, or both players merged
	typedef struct packed {
		logic coin;
		logic start2;
		logic start1;
		logic rccw;
		logic rcw;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_t;

	// Record carried through the three pipeline stages
	typedef struct packed {
		pad_t                   merged;
		pad_t                   p1;
		pad_t                   p2;
		logic [`MCR_SPIN_W-1:0] spin;
		logic [`MCR_POS_W-1:0]  pos;
	} ctrl_t;

	typedef enum logic [1:0] {
		GAME_TAPPER  = 2'd0,
		GAME_TIMBER  = 2'd1,
		GAME_DOTRON  = 2'd2,
		GAME_JOURNEY = 2'd3
	} game_e;

	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [`MCR_WB_ADR_W-1:0] adr;
		logic [7:0]               dat;
	} wb_m2s_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_s2m_t;

endpackage

// File: hdl/mcr_input_top.sv
`timescale 1ns/1ps

`include "mcr_input_macros.svh"

module mcr_input_top import mcr_input_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  wb_m2s_t                wb_req,
	output wb_s2m_t                wb_rsp,
	input  joy_t                   joy1,
	input  joy_t                   joy2,
	input  logic [`MCR_SPIN_W-1:0] spin1,
	input  logic [`MCR_SPIN_W-1:0] spin2,
	input  logic                   vsync,
	output logic [`MCR_PORT_W-1:0] port0,
	output logic [`MCR_PORT_W-1:0] port1,
	output logic [`MCR_PORT_W-1:0] port2,
	output logic [`MCR_PORT_W-1:0] port3,
	output logic                   landscape
);

	ctrl_t                  ctrl_merge;
	ctrl_t                  ctrl_spin;
	game_e                  game;
	logic                   game_ok;
	logic [`MCR_PORT_W-1:0] dip0;
	logic                   service;

	// ============================================================
	// Configuration beside the pipeline
	// ============================================================

	config_regs u_config_regs (
		.clk_sys (clk_sys),
		.rst     (rst),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.game    (game),
		.game_ok (game_ok),
		.dip0    (dip0),
		.service (service)
	);

	// ============================================================
	// Merge, spinner, map
	// ============================================================

	control_merge u_control_merge (
		.clk_sys (clk_sys),
		.rst     (rst),
		.joy1    (joy1),
		.joy2    (joy2),
		.spin1   (spin1),
		.spin2   (spin2),
		.ctrl    (ctrl_merge)
	);

	spinner_accum u_spinner_accum (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.vsync    (vsync),
		.ctrl_in  (ctrl_merge),
		.ctrl_out (ctrl_spin)
	);

	input_port_map u_input_port_map (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ctrl      (ctrl_spin),
		.game      (game),
		.game_ok   (game_ok),
		.dip0      (dip0),
		.service   (service),
		.port0     (port0),
		.port1     (port1),
		.port2     (port2),
		.port3     (port3),
		.landscape (landscape)
	);

endmodule

// File: hdl/spinner_accum.sv
`timescale 1ns/1ps

`include "mcr_input_macros.svh"

module spinner_accum import mcr_input_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst,
	input  logic  vsync,
	input  ctrl_t ctrl_in,
	output ctrl_t ctrl_out
);

	logic                  vs_q;
	logic                  spin_msb_q;
	logic                  vs_rise;
	logic                  spin_toggle;
	logic [`MCR_POS_W-1:0] pos;
	logic [`MCR_POS_W-1:0] pos_next;
	logic [`MCR_POS_W-1:0] spin_delta;
	logic [`MCR_POS_W-1:0] step_delta;
	ctrl_t                 rec;

	// ============================================================
	// Event detection
	// ============================================================

	assign vs_rise     = vsync & ~vs_q;
	// Host flips the top bit of the spinner word with every new delta
	assign spin_toggle = ctrl_in.spin[`MCR_SPIN_W-1] ^ spin_msb_q;

	always_ff @(posedge clk_sys) begin
		vs_q       <= vsync;
		spin_msb_q <= ctrl_in.spin[`MCR_SPIN_W-1];
	end

	// ============================================================
	// Position update
	// ============================================================

	always_comb begin
		// Low byte is a signed delta, its sign extension is a no-op at 8 bits
		spin_delta = spin_toggle ? ctrl_in.spin[`MCR_POS_W-1:0] : '0;

		step_delta = '0;
		if (vs_rise && ctrl_in.merged.rcw)
			step_delta = step_delta + `MCR_SPIN_STEP;
		if (vs_rise && ctrl_in.merged.rccw)
			step_delta = step_delta - `MCR_SPIN_STEP;

		pos_next = pos + spin_delta + step_delta;
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			pos <= '0;
		else
			pos <= pos_next;
	end

	always_ff @(posedge clk_sys) begin
		rec <= ctrl_in;
	end

	always_comb begin
		ctrl_out     = rec;
		ctrl_out.pos = pos;
	end

	a_pos_cause: assert property (@(posedge clk_sys) disable iff (rst)
		(pos != $past(pos)) |-> $past(spin_toggle || vs_rise));

endmodule

// File: testbench/tb_mcr_input.sv
`timescale 1ns/1ps

`include "mcr_input_macros.svh"

module tb_mcr_input import mcr_input_pkg::*; ();

	localparam int N_RAND   = 200;
	localparam int N_DOTRON = 64;
	localparam int N_PULSE  = 8;
	localparam int N_DELTA  = 32;
	// Reset, Wishbone traffic, flushes, samples, vsync pulses and spinner deltas
	localparam int TEST_CYCLES = 5 + 30 * 3 + 20 * 6 + 3 * N_RAND + N_DOTRON + 16
		+ N_PULSE * 7 + N_DELTA * 2;
	localparam int WATCHDOG_NS = TEST_CYCLES * 10 + 5000;

	logic                   clk_sys = 1'b0;
	logic                   rst;
	wb_m2s_t                wb_req;
	wb_s2m_t                wb_rsp;
	joy_t                   joy1;
	joy_t                   joy2;
	logic [`MCR_SPIN_W-1:0] spin1;
	logic [`MCR_SPIN_W-1:0] spin2;
	logic                   vsync;
	logic [`MCR_PORT_W-1:0] port0;
	logic [`MCR_PORT_W-1:0] port1;
	logic [`MCR_PORT_W-1:0] port2;
	logic [`MCR_PORT_W-1:0] port3;
	logic                   landscape;

	int                     seed = 32'h4576ee16;
	int                     cyc_cnt = 0;
	int                     checks = 0;
	int                     err_count = 0;
	int                     test_err = 0;
	int                     tests_run = 0;
	int                     tests_failed = 0;
	string                  cur_test = "none";
	logic [7:0]             dip_val [`MCR_DIP_COUNT];
	logic [7:0]             mode_val = 8'd0;
	logic [7:0]             model_pos = 8'd0;
	logic [`MCR_SPIN_W-1:0] sel_word = '0;
	logic [32:0]            exp_q [$];
	int                     due_q [$];
	logic [31:0]            pulse_words [N_PULSE] = '{32'h0000_0100, 32'h0000_0100,
		32'h0000_0200, 32'h0000_0200, 32'h0000_0200, 32'h8000_0000, 32'h4000_0000,
		32'h0000_0300};

	mcr_input_top dut_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.joy1      (joy1),
		.joy2      (joy2),
		.spin1     (spin1),
		.spin2     (spin2),
		.vsync     (vsync),
		.port0     (port0),
		.port1     (port1),
		.port2     (port2),
		.port3     (port3),
		.landscape (landscape)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cyc_cnt <= cyc_cnt + 1;
	end

	// ============================================================
	// Reference model
	// ============================================================

	// Returns {landscape, port3, port2, port1, port0}
	// Joystick bits: 0 right, 1 left, 2 down, 3 up, 4..7 fire a..d, 10/11 start, 12 coin
	function automatic logic [32:0] ref_ports(input logic [7:0] mode, input logic [7:0] d0,
		input logic [7:0] d1, input logic [31:0] j1, input logic [31:0] j2,
		input logic [7:0] pos);
		logic [31:0] m;
		logic        coin;
		logic        svc;
		logic [7:0]  p0;
		logic [7:0]  p1;
		logic [7:0]  p2;
		m    = j1 | j2;
		svc  = d1[0];
		coin = m[12] | ((mode == 8'd2) & (m[10] | m[11]));
		case (mode)
			8'd0: begin
				p0 = {svc, 3'b000, m[11], m[10], 1'b0, coin};
				p1 = {3'b000, m[4], m[3], m[2], m[1], m[0]};
				p2 = p1;
			end
			8'd1: begin
				p0 = {svc, 3'b000, m[11], m[10], 1'b0, coin};
				p1 = {2'b00, j1[4], j1[5], j1[3], j1[2], j1[1], j1[0]};
				p2 = {2'b00, j2[4], j2[5], j2[3], j2[2], j2[1], j2[0]};
			end
			8'd2: begin
				p0 = {svc, 2'b00, m[4], m[11], m[10], 1'b0, coin};
				p1 = {1'b0, pos[7:1]};
				p2 = {1'b0, m[5], m[6], m[7], m[2], m[3], m[0], m[1]};
			end
			8'd3: begin
				p0 = {svc, 2'b00, m[4], m[11], m[10], 1'b0, coin};
				p1 = {4'b0000, m[2], m[3], m[0], m[1]};
				p2 = {3'b000, m[4], m[2], m[3], m[0], m[1]};
			end
			default: begin
				p0 = 8'h00;
				p1 = 8'h00;
				p2 = 8'h00;
			end
		endcase
		return {mode != 8'd3, d0, ~p2, ~p1, ~p0};
	endfunction

	task automatic note_error();
		err_count++;
		test_err++;
	endtask

	task automatic check(input string what, input logic [32:0] exp, input logic [32:0] act);
		checks++;
		if (exp !== act) begin
			$display("Error: [%s] %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
			note_error();
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		while (due_q.size() > 0 && due_q[0] == cyc_cnt) begin
			check("ports {landscape,p3,p2,p1,p0}", exp_q.pop_front(),
				{landscape, port3, port2, port1, port0});
			void'(due_q.pop_front());
		end
	end

	// ============================================================
	// Stimulus tasks
	// ============================================================

	task automatic drive_sample(input logic [31:0] j1, input logic [31:0] j2);
		@(posedge clk_sys);
		#1;
		joy1 = joy_t'(j1);
		joy2 = joy_t'(j2);
		exp_q.push_back(ref_ports(mode_val, dip_val[0], dip_val[1], j1, j2, model_pos));
		due_q.push_back(cyc_cnt + 3);
	endtask

	task automatic flush();
		while (exp_q.size() != 0)
			@(negedge clk_sys);
		@(posedge clk_sys);
	endtask

	task automatic wb_access(input logic we, input logic [`MCR_WB_ADR_W-1:0] adr,
		input logic [7:0] wdat, output logic [7:0] rdat);
		int n;
		n = 0;
		rdat = '0;
		@(posedge clk_sys);
		#1;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(posedge clk_sys);
			#1;
			n++;
		end while (!wb_rsp.ack && n < 16);
		if (wb_rsp.ack) begin
			rdat = wb_rsp.dat;
			check($sformatf("ack latency at address %0d", adr), 33'(1), 33'(n));
		end else begin
			$display("Error: [%s] no Wishbone ack for address %0d after %0d cycles",
				cur_test, adr, n);
			note_error();
		end
		wb_req = '0;
	endtask

	task automatic set_mode(input logic [7:0] v);
		logic [7:0] unused_dat;
		flush();
		wb_access(1'b1, `MCR_WB_ADR_W'(`MCR_MODE_ADR), v, unused_dat);
		mode_val = v;
	endtask

	// Raise vsync once while holding the rotate buttons of one joystick word
	task automatic pulse_vsync(input logic [31:0] j);
		@(posedge clk_sys);
		#1;
		joy1 = joy_t'(j);
		joy2 = '0;
		repeat (3) @(posedge clk_sys);
		#1;
		vsync = 1'b1;
		if (j[8] | j[31])
			model_pos = model_pos + 8'd5;
		if (j[9] | j[30])
			model_pos = model_pos - 8'd5;
		@(posedge clk_sys);
		#1;
		vsync = 1'b0;
		drive_sample(j, 32'h0);
	endtask

	// New delta on spinner two, bit 8 flips to mark it
	task automatic spin2_delta(input logic [7:0] d);
		logic [`MCR_SPIN_W-1:0] w;
		@(posedge clk_sys);
		#1;
		w = {~spin2[`MCR_SPIN_W-1], d};
		if (w[`MCR_SPIN_W-1] != sel_word[`MCR_SPIN_W-1])
			model_pos = model_pos + d;
		sel_word = w;
		spin2 = w;
		drive_sample(32'h0, 32'h0);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err = 0;
	endtask

	task automatic end_test();
		flush();
		tests_run++;
		if (test_err == 0) begin
			$display("Test %s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", cur_test, test_err);
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [7:0] rd;
		rst    = 1'b1;
		wb_req = '0;
		joy1   = '0;
		joy2   = '0;
		spin1  = '0;
		spin2  = '0;
		vsync  = 1'b0;
		for (int i = 0; i < `MCR_DIP_COUNT; i++)
			dip_val[i] = `MCR_PORT_IDLE;
		repeat (5) @(posedge clk_sys);
		#1;
		rst = 1'b0;

		start_test("config_regs");
		for (int i = 0; i < `MCR_DIP_COUNT; i++) begin
			dip_val[i] = 8'($random(seed));
			if (i == 1)
				dip_val[i][0] = 1'b1;
			wb_access(1'b1, `MCR_WB_ADR_W'(i), dip_val[i], rd);
		end
		// Timber differs from the reset mode
		mode_val = 8'd1;
		wb_access(1'b1, `MCR_WB_ADR_W'(`MCR_MODE_ADR), mode_val, rd);
		for (int i = 0; i < 16; i++) begin
			wb_access(1'b0, `MCR_WB_ADR_W'(i), 8'h00, rd);
			if (i < `MCR_DIP_COUNT)
				check($sformatf("dip %0d readback", i), 33'(dip_val[i]), 33'(rd));
			else if (i == `MCR_MODE_ADR)
				check("mode readback", 33'(mode_val), 33'(rd));
			else
				check($sformatf("unmapped %0d readback", i), 33'(`MCR_PORT_IDLE), 33'(rd));
		end
		drive_sample(32'h0, 32'h0);
		flush();
		check("port3 holds dip 0", 33'(dip_val[0]), 33'(port3));
		check("service bit in port0", 33'(0), 33'(port0[7]));
		end_test();

		start_test("tapper_map");
		set_mode(8'd0);
		repeat (N_RAND) drive_sample($random(seed), $random(seed));
		end_test();

		start_test("timber_map");
		set_mode(8'd1);
		repeat (N_RAND) drive_sample($random(seed), $random(seed));
		end_test();

		start_test("journey_map");
		set_mode(8'd3);
		repeat (N_RAND) drive_sample($random(seed), $random(seed));
		flush();
		check("landscape in Journey", 33'(0), 33'(landscape));
		set_mode(8'd0);
		drive_sample(32'h0, 32'h0);
		flush();
		check("landscape after leaving Journey", 33'(1), 33'(landscape));
		end_test();

		start_test("dotron_coin");
		set_mode(8'd2);
		drive_sample(32'h0000_0400, 32'h0);
		drive_sample(32'h0, 32'h0000_0800);
		drive_sample(32'h0, 32'h0);
		repeat (N_DOTRON) drive_sample($random(seed), $random(seed));
		end_test();

		start_test("spinner");
		drive_sample(32'h0, 32'h0);
		for (int i = 0; i < N_PULSE; i++)
			pulse_vsync(pulse_words[i]);
		repeat (N_DELTA) spin2_delta(8'($random(seed)));
		end_test();

		start_test("unknown_mode");
		set_mode(8'd7);
		repeat (16) drive_sample($random(seed), $random(seed));
		flush();
		check("port3 in unknown mode", 33'(dip_val[0]), 33'(port3));
		end_test();

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, err_count);
		if (err_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
